//--- common/cart_bus_pkg.sv
`include "cart_params.svh"

package cart_bus_pkg;

  // loROM splits the offset at a15, each bank maps 32 KB of ROM.
  typedef struct packed {
    logic [7:0]                bank;
    logic                      a15;
    logic [`CART_ADDR_W-10:0]  offset;
  } lorom_addr_t;

  // hiROM uses the whole 64 KB of a bank.
  typedef struct packed {
    logic [7:0]                bank;
    logic [`CART_ADDR_W-9:0]   offset;
  } hirom_addr_t;

  // one cpu address, read through either mapping.
  typedef union packed {
    lorom_addr_t lorom;
    hirom_addr_t hirom;
  } cart_addr_u;

endpackage

//--- common/cart_params.svh
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

// cpu side of the cartridge bus.
`define CART_ADDR_W 24
`define CART_DATA_W 8

// memory side, one ROM word is 16 bits wide.
`define ROM_ADDR_W 24
`define BSRAM_ADDR_W 20

// highest bank of the MSU window, mirrored again with bank bit 7 set.
`define MSU_BANK_LIMIT 8'h3f

// first of eight MSU registers, taken from the 16-bit bank offset.
`define MSU_BASE 16'h2000

`endif

//--- common/cpu_bus_if.sv
`timescale 1ns/1ps
`include "cart_params.svh"

interface cpu_bus_if
  import cart_bus_pkg::*;
();

  cart_addr_u              addr;
  logic                    rd_n;
  logic                    wr_n;
  logic [`CART_DATA_W-1:0] wdata;
  logic                    cyc_ce;  // the cycle completes on the edge where this is high.

  modport target (
    input addr,
    input rd_n,
    input wr_n,
    input wdata,
    input cyc_ce
  );

endinterface

//--- common/msu_pkg.sv
package msu_pkg;

  // register offsets inside the MSU window.
  localparam logic [2:0] MSU_REG_STATUS   = 3'd0;
  localparam logic [2:0] MSU_REG_TRACK_LO = 3'd4;
  localparam logic [2:0] MSU_REG_TRACK_HI = 3'd5;
  localparam logic [2:0] MSU_REG_VOLUME   = 3'd6;
  localparam logic [2:0] MSU_REG_CONTROL  = 3'd7;

  // status byte layout.
  localparam int MSU_ST_BUSY    = 6;
  localparam int MSU_ST_REPEAT  = 5;
  localparam int MSU_ST_PLAYING = 4;
  localparam int MSU_ST_MISSING = 3;

  localparam logic [2:0] MSU_REVISION = 3'd1;

  // identification string, first character is read at offset 2.
  localparam logic [47:0] MSU_ID = "S-MSU1";

endpackage

//--- hw/cart_map_top.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module cart_map_top (
  input  logic                     mclk,
  input  logic                     rst_n,
  input  logic                     sysclkf_ce,
  input  logic [`CART_ADDR_W-1:0]  ca,
  input  logic                     cpurd_n,
  input  logic                     cpuwr_n,
  input  logic [`CART_DATA_W-1:0]  cpu_do,
  input  logic [7:0]               map_ctrl,
  input  logic [`ROM_ADDR_W-1:0]   rom_mask,
  input  logic [`BSRAM_ADDR_W-1:0] bsram_mask,
  input  logic [15:0]              rom_q,
  input  logic [7:0]               bsram_q,
  input  logic                     msu_enable,
  input  logic                     msu_track_mounting,
  input  logic                     msu_track_missing,
  input  logic                     msu_audio_stop,
  output logic [`CART_DATA_W-1:0]  cpu_di,
  output logic [`ROM_ADDR_W-1:0]   rom_addr,
  output logic                     rom_ce_n,
  output logic                     rom_oe_n,
  output logic [`BSRAM_ADDR_W-1:0] bsram_addr,
  output logic [7:0]               bsram_d,
  output logic                     bsram_ce_n,
  output logic                     bsram_oe_n,
  output logic                     bsram_we_n,
  output logic [15:0]              msu_track_num,
  output logic                     msu_track_request,
  output logic [7:0]               msu_volume,
  output logic                     msu_audio_repeat,
  output logic                     msu_audio_playing
);

  logic [`CART_DATA_W-1:0] map_do;
  logic [`CART_DATA_W-1:0] msu_do;
  logic                    msu_sel;

  cpu_bus_if bus ();

  assign bus.addr   = ca;
  assign bus.rd_n   = cpurd_n;
  assign bus.wr_n   = cpuwr_n;
  assign bus.wdata  = cpu_do;
  assign bus.cyc_ce = sysclkf_ce;

  lhrom_map u_map (
    .mclk       (mclk),
    .rst_n      (rst_n),
    .bus        (bus.target),
    .map_ctrl   (map_ctrl),
    .rom_mask   (rom_mask),
    .bsram_mask (bsram_mask),
    .rom_q      (rom_q),
    .bsram_q    (bsram_q),
    .rom_addr   (rom_addr),
    .rom_ce_n   (rom_ce_n),
    .rom_oe_n   (rom_oe_n),
    .bsram_addr (bsram_addr),
    .bsram_d    (bsram_d),
    .bsram_ce_n (bsram_ce_n),
    .bsram_oe_n (bsram_oe_n),
    .bsram_we_n (bsram_we_n),
    .map_do     (map_do)
  );

  msu_regs u_msu (
    .mclk           (mclk),
    .rst_n          (rst_n),
    .bus            (bus.target),
    .enable         (msu_enable),
    .track_mounting (msu_track_mounting),
    .track_missing  (msu_track_missing),
    .audio_stop     (msu_audio_stop),
    .msu_do         (msu_do),
    .msu_sel        (msu_sel),
    .track_num      (msu_track_num),
    .track_request  (msu_track_request),
    .volume         (msu_volume),
    .audio_repeat   (msu_audio_repeat),
    .audio_playing  (msu_audio_playing)
  );

  // the MSU window shadows whatever the mapper returns there.
  assign cpu_di = msu_sel ? msu_do : map_do;

endmodule

//--- lhrom/lhrom_map.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module lhrom_map
  import cart_bus_pkg::*;
(
  input  logic                     mclk,
  input  logic                     rst_n,
  cpu_bus_if.target                bus,
  input  logic [7:0]               map_ctrl,
  input  logic [`ROM_ADDR_W-1:0]   rom_mask,
  input  logic [`BSRAM_ADDR_W-1:0] bsram_mask,
  input  logic [15:0]              rom_q,
  input  logic [7:0]               bsram_q,
  output logic [`ROM_ADDR_W-1:0]   rom_addr,
  output logic                     rom_ce_n,
  output logic                     rom_oe_n,
  output logic [`BSRAM_ADDR_W-1:0] bsram_addr,
  output logic [7:0]               bsram_d,
  output logic                     bsram_ce_n,
  output logic                     bsram_oe_n,
  output logic                     bsram_we_n,
  output logic [`CART_DATA_W-1:0]  map_do
);

  cart_addr_u                 a;
  logic                       hirom;
  logic [7:0]                 bank;
  logic                       wram_bank;
  logic                       bsram_hit;
  logic                       rom_hit;
  logic                       rd;
  logic                       wr;
  logic [`ROM_ADDR_W-1:0]     rom_addr_nx;
  logic [`BSRAM_ADDR_W-1:0]   bsram_addr_nx;

  assign a     = bus.addr;
  assign hirom = map_ctrl[0];
  assign bank  = a.lorom.bank;
  assign rd    = !bus.rd_n;
  assign wr    = !bus.wr_n;

  // banks 7E and 7F belong to the console work RAM.
  assign wram_bank = (bank[7:1] == 7'b0111111);

  always_comb begin
    bsram_hit = 1'b0;
    if (bsram_mask != '0) begin
      if (hirom) begin
        // 20-3F and A0-BF, offsets 6000-7FFF.
        bsram_hit = (bank[6:5] == 2'b01) && (a.hirom.offset[15:13] == 3'b011);
      end else begin
        // 70-7D and F0-FD, lower half of the bank.
        bsram_hit = (bank[6:4] == 3'b111) && (bank[3:1] != 3'b111) && !a.lorom.a15;
      end
    end
  end

  assign rom_hit = !bsram_hit && !wram_bank && (a.lorom.a15 || bank[6]);

  always_comb begin
    if (hirom) begin
      rom_addr_nx   = {{(`ROM_ADDR_W-22){1'b0}}, bank[5:0], a.hirom.offset};
      bsram_addr_nx = {{(`BSRAM_ADDR_W-18){1'b0}}, bank[4:0], a.hirom.offset[12:0]};
    end else begin
      rom_addr_nx   = {{(`ROM_ADDR_W-22){1'b0}}, bank[6:0], a.lorom.offset};
      bsram_addr_nx = {{(`BSRAM_ADDR_W-19){1'b0}}, bank[3:0], a.lorom.offset};
    end
  end

  // strobes hold the decode of the last completed cycle.
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      rom_addr   <= '0;
      rom_ce_n   <= 1'b1;
      rom_oe_n   <= 1'b1;
      bsram_addr <= '0;
      bsram_d    <= '0;
      bsram_ce_n <= 1'b1;
      bsram_oe_n <= 1'b1;
      bsram_we_n <= 1'b1;
    end else if (bus.cyc_ce) begin
      rom_ce_n   <= !(rom_hit && rd);  // ROM is read only.
      rom_oe_n   <= !(rom_hit && rd);
      bsram_ce_n <= !(bsram_hit && (rd || wr));
      bsram_oe_n <= !(bsram_hit && rd);
      bsram_we_n <= !(bsram_hit && wr);
      if (rom_hit && rd) begin
        rom_addr <= rom_addr_nx & rom_mask;
      end
      if (bsram_hit && (rd || wr)) begin
        bsram_addr <= bsram_addr_nx & bsram_mask;
      end
      if (bsram_hit && wr) begin
        bsram_d <= bus.wdata;
      end
    end
  end

  always_comb begin
    if (!rom_oe_n) begin
      map_do = rom_addr[0] ? rom_q[15:8] : rom_q[7:0];  // odd bytes sit in the high half.
    end else if (!bsram_oe_n) begin
      map_do = bsram_q;
    end else begin
      map_do = '0;
    end
  end

endmodule

//--- msu/msu_regs.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module msu_regs
  import msu_pkg::*;
(
  input  logic                    mclk,
  input  logic                    rst_n,
  cpu_bus_if.target               bus,
  input  logic                    enable,
  input  logic                    track_mounting,
  input  logic                    track_missing,
  input  logic                    audio_stop,
  output logic [`CART_DATA_W-1:0] msu_do,
  output logic                    msu_sel,
  output logic [15:0]             track_num,
  output logic                    track_request,
  output logic [7:0]              volume,
  output logic                    audio_repeat,
  output logic                    audio_playing
);

  logic [7:0]  bank;
  logic [15:0] offset;
  logic [2:0]  reg_off;
  logic        in_window;
  logic        wr_cyc;
  logic [7:0]  status;

  assign bank    = bus.addr.hirom.bank;
  assign offset  = bus.addr.hirom.offset;
  assign reg_off = offset[2:0];

  // system area banks only, both halves of the map.
  assign in_window = enable && ({1'b0, bank[6:0]} <= `MSU_BANK_LIMIT) &&
                     ((offset >> 3) == (`MSU_BASE >> 3));

  assign wr_cyc = bus.cyc_ce && in_window && !bus.wr_n;

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      track_num     <= '0;
      volume        <= '0;
      track_request <= 1'b0;
      audio_playing <= 1'b0;
      audio_repeat  <= 1'b0;
    end else begin
      track_request <= 1'b0;
      if (audio_stop) begin
        audio_playing <= 1'b0;  // a control write below takes priority.
      end
      if (wr_cyc) begin
        case (reg_off)
          MSU_REG_TRACK_LO: track_num[7:0] <= bus.wdata;
          MSU_REG_TRACK_HI: begin
            track_num[15:8] <= bus.wdata;
            track_request   <= 1'b1;
            audio_playing   <= 1'b0;  // a new track starts stopped.
          end
          MSU_REG_VOLUME: volume <= bus.wdata;
          MSU_REG_CONTROL: begin
            audio_playing <= bus.wdata[0];
            audio_repeat  <= bus.wdata[1];
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    status                 = '0;
    status[MSU_ST_BUSY]    = track_mounting;
    status[MSU_ST_REPEAT]  = audio_repeat;
    status[MSU_ST_PLAYING] = audio_playing;
    status[MSU_ST_MISSING] = track_missing;
    status[2:0]            = MSU_REVISION;
  end

  assign msu_sel = in_window && !bus.rd_n;

  always_comb begin
    if (reg_off == MSU_REG_STATUS) begin
      msu_do = status;
    end else if (reg_off >= 3'd2) begin
      msu_do = MSU_ID[8 * (3'd7 - reg_off) +: 8];
    end else begin
      msu_do = '0;  // the audio data port is not present.
    end
  end

endmodule

//--- test/cart_map_assert.sv
`timescale 1ns/1ps

module cart_map_assert (
  input logic clk,
  input logic rst_n,
  input logic rom_ce_n,
  input logic bsram_ce_n,
  input logic bsram_oe_n,
  input logic bsram_we_n,
  input logic track_request
);

  // only one memory may own the data bus.
  a_one_chip: assert property (@(posedge clk) disable iff (!rst_n) rom_ce_n || bsram_ce_n)
    else $error("rom_ce_n and bsram_ce_n are both low");

  a_rd_or_wr: assert property (@(posedge clk) disable iff (!rst_n) bsram_we_n || bsram_oe_n)
    else $error("bsram_we_n and bsram_oe_n are both low");

  a_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                track_request |=> !track_request)
    else $error("track_request held high for two cycles");

endmodule

bind lhrom_map cart_map_assert u_map_assert (
  .clk (mclk), .rst_n (rst_n), .rom_ce_n (rom_ce_n), .bsram_ce_n (bsram_ce_n),
  .bsram_oe_n (bsram_oe_n), .bsram_we_n (bsram_we_n), .track_request (1'b0)
);

bind msu_regs cart_map_assert u_msu_assert (
  .clk (mclk), .rst_n (rst_n), .rom_ce_n (1'b1), .bsram_ce_n (1'b1),
  .bsram_oe_n (1'b1), .bsram_we_n (1'b1), .track_request (track_request)
);

//--- test/cart_map_tb.sv
`timescale 1ns/1ps
`include "cart_params.svh"

module cart_map_tb
  import msu_pkg::*;
();

  localparam int MAX_ROWS = 40;
  localparam logic [`ROM_ADDR_W-1:0]   LO_RM = 24'h01ffff;  // 128 KB LoROM image.
  localparam logic [`ROM_ADDR_W-1:0]   HI_RM = 24'h3fffff;
  localparam logic [`BSRAM_ADDR_W-1:0] LO_BM = 20'h01fff;
  localparam logic [`BSRAM_ADDR_W-1:0] HI_BM = 20'h07fff;

  logic                     mclk;
  logic                     rst_n;
  logic                     sysclkf_ce;
  logic [`CART_ADDR_W-1:0]  ca;
  logic                     cpurd_n;
  logic                     cpuwr_n;
  logic [`CART_DATA_W-1:0]  cpu_do;
  logic [7:0]               map_ctrl;
  logic [`ROM_ADDR_W-1:0]   rom_mask;
  logic [`BSRAM_ADDR_W-1:0] bsram_mask;
  logic [15:0]              rom_q;
  logic [7:0]               bsram_q;
  logic                     msu_enable;
  logic                     msu_track_mounting;
  logic                     msu_track_missing;
  logic                     msu_audio_stop;
  logic [`CART_DATA_W-1:0]  cpu_di;
  logic [`ROM_ADDR_W-1:0]   rom_addr;
  logic                     rom_ce_n;
  logic                     rom_oe_n;
  logic [`BSRAM_ADDR_W-1:0] bsram_addr;
  logic [7:0]               bsram_d;
  logic                     bsram_ce_n;
  logic                     bsram_oe_n;
  logic                     bsram_we_n;
  logic [15:0]              msu_track_num;
  logic                     msu_track_request;
  logic [7:0]               msu_volume;
  logic                     msu_audio_repeat;
  logic                     msu_audio_playing;

  // one row per bus cycle, msu_in is {mounting, missing, stop}.
  logic [7:0]               t_ctrl   [MAX_ROWS];
  logic [`ROM_ADDR_W-1:0]   t_rmask  [MAX_ROWS];
  logic [`BSRAM_ADDR_W-1:0] t_bmask  [MAX_ROWS];
  logic                     t_wr     [MAX_ROWS];
  logic [`CART_ADDR_W-1:0]  t_addr   [MAX_ROWS];
  logic [7:0]               t_wdata  [MAX_ROWS];
  logic                     t_en     [MAX_ROWS];
  logic [2:0]               t_msu_in [MAX_ROWS];
  int                       n_rows = 0;
  int                       cycles = 0;
  int                       timeout_limit = 0;

  logic [`ROM_ADDR_W-1:0]   e_rom_addr;
  logic [`BSRAM_ADDR_W-1:0] e_bsram_addr;
  logic [7:0]               e_bsram_d;
  logic                     e_rom_ce_n;
  logic                     e_rom_oe_n;
  logic                     e_bsram_ce_n;
  logic                     e_bsram_oe_n;
  logic                     e_bsram_we_n;
  logic [7:0]               e_di;
  logic [15:0]              e_track;
  logic                     e_req;
  logic [7:0]               e_vol;
  logic                     e_rep;
  logic                     e_play;

  cart_map_top u_dut (.*);

  initial begin
    mclk = 1'b0;
    forever #5 mclk = ~mclk;
  end

  always @(posedge mclk) begin
    cycles = cycles + 1;
    if (timeout_limit != 0 && cycles > timeout_limit) begin
      $display("timeout, the test loop did not finish within %0d cycles", timeout_limit);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  task automatic add_row(input logic hi, input logic [`ROM_ADDR_W-1:0] rmask,
                         input logic [`BSRAM_ADDR_W-1:0] bmask, input logic wr,
                         input logic [`CART_ADDR_W-1:0] addr, input logic [7:0] wdata,
                         input logic en, input logic [2:0] msu_in);
    t_ctrl[n_rows]   = {7'd0, hi};
    t_rmask[n_rows]  = rmask;
    t_bmask[n_rows]  = bmask;
    t_wr[n_rows]     = wr;
    t_addr[n_rows]   = addr;
    t_wdata[n_rows]  = wdata;
    t_en[n_rows]     = en;
    t_msu_in[n_rows] = msu_in;
    n_rows = n_rows + 1;
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("sim failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic predict(input int i, input logic [15:0] rq, input logic [7:0] bq);
    logic [7:0]  bank;
    logic [15:0] off;
    logic        hi;
    logic        wr;
    logic        bs_hit;
    logic        rom_hit;
    logic        in_win;
    bank   = t_addr[i][23:16];
    off    = t_addr[i][15:0];
    hi     = t_ctrl[i][0];
    wr     = t_wr[i];
    bs_hit = 1'b0;
    if (t_bmask[i] != 0) begin
      if (hi)
        bs_hit = ((bank >= 8'h20 && bank <= 8'h3f) || (bank >= 8'ha0 && bank <= 8'hbf)) &&
                 off >= 16'h6000 && off <= 16'h7fff;
      else
        bs_hit = ((bank >= 8'h70 && bank <= 8'h7d) || (bank >= 8'hf0 && bank <= 8'hfd)) &&
                 off < 16'h8000;
    end
    // 7E and 7F are console work RAM.
    rom_hit = !bs_hit && bank != 8'h7e && bank != 8'h7f &&
              (off >= 16'h8000 || (bank >= 8'h40 && bank <= 8'h7d) || bank >= 8'hc0);
    e_rom_ce_n   = !(rom_hit && !wr);
    e_rom_oe_n   = e_rom_ce_n;
    e_bsram_ce_n = !bs_hit;
    e_bsram_oe_n = !(bs_hit && !wr);
    e_bsram_we_n = !(bs_hit && wr);
    if (!e_rom_oe_n)
      e_rom_addr = (hi ? bank[5:0] * 32'h10000 + off : bank[6:0] * 32'h8000 + off[14:0]) &
                   t_rmask[i];
    if (bs_hit)
      e_bsram_addr = (hi ? bank[4:0] * 32'h2000 + off[12:0] : bank[3:0] * 32'h8000 + off[14:0]) &
                     t_bmask[i];
    if (bs_hit && wr)
      e_bsram_d = t_wdata[i];
    in_win = t_en[i] && (bank <= 8'h3f || (bank >= 8'h80 && bank <= 8'hbf)) &&
             off >= `MSU_BASE && off <= `MSU_BASE + 7;
    e_req = 1'b0;
    if (t_msu_in[i][0])
      e_play = 1'b0;
    if (in_win && wr) begin
      case (off[2:0])
        MSU_REG_TRACK_LO: e_track[7:0] = t_wdata[i];
        MSU_REG_TRACK_HI: begin
          e_track[15:8] = t_wdata[i];
          e_req         = 1'b1;
          e_play        = 1'b0;
        end
        MSU_REG_VOLUME: e_vol = t_wdata[i];
        MSU_REG_CONTROL: begin
          e_play = t_wdata[i][0];  // wins over a stop in the same cycle.
          e_rep  = t_wdata[i][1];
        end
        default: ;
      endcase
    end
    if (in_win && !wr) begin
      case (off[2:0])
        3'd0: begin
          e_di                 = 8'h01;  // revision 1.
          e_di[MSU_ST_BUSY]    = t_msu_in[i][2];
          e_di[MSU_ST_REPEAT]  = e_rep;
          e_di[MSU_ST_PLAYING] = e_play;
          e_di[MSU_ST_MISSING] = t_msu_in[i][1];
        end
        3'd1: e_di = 8'h00;
        3'd2: e_di = "S";
        3'd3: e_di = "-";
        3'd4: e_di = "M";
        3'd5: e_di = "S";
        3'd6: e_di = "U";
        default: e_di = "1";
      endcase
    end else if (!e_rom_oe_n) begin
      e_di = e_rom_addr[0] ? rq[15:8] : rq[7:0];
    end else if (!e_bsram_oe_n) begin
      e_di = bq;
    end else begin
      e_di = 8'h00;
    end
  endtask

  initial begin
    int          seed;
    int          i;
    logic [15:0] rq;
    logic [7:0]  bq;
    seed = $urandom(32'h8f508373);
    add_row(0, LO_RM, LO_BM, 0, 24'h008000, 8'h00, 0, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'h019abd, 8'h00, 0, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'h85fff2, 8'h00, 0, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'h401234, 8'h00, 0, 3'b000);
    add_row(1, HI_RM, HI_BM, 0, 24'hc12345, 8'h00, 0, 3'b000);
    add_row(1, HI_RM, HI_BM, 0, 24'hffffff, 8'h00, 0, 3'b000);
    add_row(1, HI_RM, HI_BM, 0, 24'h008001, 8'h00, 0, 3'b000);
    add_row(1, HI_RM, HI_BM, 0, 24'h7e8000, 8'h00, 0, 3'b000);
    add_row(0, LO_RM, LO_BM, 1, 24'h700123, 8'ha5, 0, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'h700123, 8'h00, 0, 3'b000);
    add_row(0, LO_RM, LO_BM, 1, 24'hf17abc, 8'h5a, 0, 3'b000);
    add_row(1, HI_RM, HI_BM, 1, 24'h216abc, 8'h3c, 0, 3'b000);
    add_row(1, HI_RM, HI_BM, 0, 24'h216abc, 8'h00, 0, 3'b000);
    add_row(1, HI_RM, HI_BM, 0, 24'hbf7fff, 8'h00, 0, 3'b000);
    add_row(0, LO_RM, 20'h0, 0, 24'h700123, 8'h00, 0, 3'b000);
    add_row(1, HI_RM, 20'h0, 0, 24'h216abc, 8'h00, 0, 3'b000);
    add_row(0, LO_RM, LO_BM, 1, 24'h002004, 8'h34, 1, 3'b000);
    add_row(0, LO_RM, LO_BM, 1, 24'h002005, 8'h12, 1, 3'b000);
    add_row(0, LO_RM, LO_BM, 1, 24'h802006, 8'h80, 1, 3'b000);
    add_row(0, LO_RM, LO_BM, 1, 24'h002007, 8'h03, 1, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'h002000, 8'h00, 1, 3'b100);
    add_row(0, LO_RM, LO_BM, 0, 24'h3f2000, 8'h00, 1, 3'b011);
    add_row(0, LO_RM, LO_BM, 0, 24'h002001, 8'h00, 1, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'h002002, 8'h00, 1, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'h802003, 8'h00, 1, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'h3f2004, 8'h00, 1, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'hbf2005, 8'h00, 1, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'h002006, 8'h00, 1, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'h002007, 8'h00, 1, 3'b000);
    add_row(0, LO_RM, LO_BM, 0, 24'h002002, 8'h00, 0, 3'b000);
    add_row(0, LO_RM, LO_BM, 1, 24'h002007, 8'h01, 1, 3'b001);
    add_row(0, LO_RM, LO_BM, 0, 24'h402000, 8'h00, 1, 3'b000);
    timeout_limit = n_rows * 4 + 5 + 20;
    rst_n = 1'b0;
    sysclkf_ce = 1'b0;
    ca = '0;
    cpurd_n = 1'b1;
    cpuwr_n = 1'b1;
    cpu_do = '0;
    map_ctrl = '0;
    rom_mask = '0;
    bsram_mask = '0;
    rom_q = '0;
    bsram_q = '0;
    msu_enable = 1'b0;
    msu_track_mounting = 1'b0;
    msu_track_missing = 1'b0;
    msu_audio_stop = 1'b0;
    e_rom_addr = '0;
    e_bsram_addr = '0;
    e_bsram_d = '0;
    e_track = '0;
    e_vol = '0;
    e_rep = 1'b0;
    e_play = 1'b0;
    repeat (5) @(posedge mclk);
    rst_n <= 1'b1;
    for (i = 0; i < n_rows; i++) begin
      rq = $urandom;
      bq = $urandom;
      @(posedge mclk);
      map_ctrl           <= t_ctrl[i];
      rom_mask           <= t_rmask[i];
      bsram_mask         <= t_bmask[i];
      ca                 <= t_addr[i];
      cpurd_n            <= t_wr[i];
      cpuwr_n            <= !t_wr[i];
      cpu_do             <= t_wdata[i];
      msu_enable         <= t_en[i];
      msu_track_mounting <= t_msu_in[i][2];
      msu_track_missing  <= t_msu_in[i][1];
      msu_audio_stop     <= t_msu_in[i][0];
      rom_q              <= rq;
      bsram_q            <= bq;
      sysclkf_ce         <= 1'b1;
      predict(i, rq, bq);
      @(posedge mclk);
      sysclkf_ce     <= 1'b0;
      msu_audio_stop <= 1'b0;  // stop is seen on the cycle-end edge only.
      @(negedge mclk);
      check("rom_addr", rom_addr, e_rom_addr);
      check("rom_ce_n", rom_ce_n, e_rom_ce_n);
      check("rom_oe_n", rom_oe_n, e_rom_oe_n);
      check("bsram_addr", bsram_addr, e_bsram_addr);
      check("bsram_d", bsram_d, e_bsram_d);
      check("bsram_ce_n", bsram_ce_n, e_bsram_ce_n);
      check("bsram_oe_n", bsram_oe_n, e_bsram_oe_n);
      check("bsram_we_n", bsram_we_n, e_bsram_we_n);
      check("cpu_di", cpu_di, e_di);
      check("msu_track_num", msu_track_num, e_track);
      check("msu_track_request", msu_track_request, e_req);
      check("msu_volume", msu_volume, e_vol);
      check("msu_audio_repeat", msu_audio_repeat, e_rep);
      check("msu_audio_playing", msu_audio_playing, e_play);
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+common
common/cart_bus_pkg.sv
common/msu_pkg.sv
common/cpu_bus_if.sv
lhrom/lhrom_map.sv
msu/msu_regs.sv
hw/cart_map_top.sv
test/cart_map_assert.sv
test/cart_map_tb.sv
